// File: compile.f
+incdir+.
opl3_pkg.sv
opl3_host_port.sv
opl3_reg_array.sv
opl3_reg_decode.sv
opl3_timers.sv
opl3_regs_top.sv
tb_opl3_regs.sv

// File: opl3_cfg.svh
//////////////////////////////////////////////////////////////////////
// OPL3 register subsystem configuration
//   register array depth and bank split
//   timer prescaler lengths
//   register field widths
//////////////////////////////////////////////////////////////////////
`ifndef OPL3_CFG_SVH
`define OPL3_CFG_SVH

`define OPL3_NUM_REGS       512     // two banks of 256
`define OPL3_BANK_OFFSET    256     // first register of bank 1
`define OPL3_ADDR_W         9       // bank bit + register offset
`define OPL3_DATA_W         8

`define OPL3_TIMER1_TICK    8       // clocks per timer 1 tick, short for sim
`define OPL3_TIMER2_MULT    4       // timer 2 tick = timer 1 tick * this

`define OPL3_FNUM_W         10
`define OPL3_BLOCK_W        3
`define OPL3_MULT_W         4
`define OPL3_ENV_W          4       // ar, dr, sl, rr
`define OPL3_TL_W           6
`define OPL3_KSL_W          2
`define OPL3_WS_W           3
`define OPL3_FB_W           3
`define OPL3_TIMER_W        8
`define OPL3_CONN_SEL_W     6

`endif

// File: opl3_host_port.sv
//////////////////////////////////////////////////////////////////////
// OPL3 host port
//   latches bank and register address on the address strobe
//   turns the data strobe into one register array write
//   routes the flag reset command to the timers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opl3_host_port (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 addr_wr,
    input  wire                 data_wr,
    input  wire                 bank,
    input  wire opl3_pkg::reg_data_t host_data,
    output logic                wr_en,
    output opl3_pkg::reg_addr_t wr_addr,
    output opl3_pkg::reg_data_t wr_data,
    output logic                flag_reset
);
    import opl3_pkg::*;

    reg_addr_t addr_q;          // latched {bank, offset}
    logic      is_flag_cmd;

    // bank 0 reg 0x04 with bit 7 set only clears the timer flags
    assign is_flag_cmd = (addr_q == reg_addr_t'('h004)) && host_data[7];

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q     <= '0;
            wr_en      <= 1'b0;
            flag_reset <= 1'b0;
        end else begin
            if (addr_wr) begin
                addr_q <= {bank, host_data};
            end
            wr_en      <= data_wr && !is_flag_cmd;
            flag_reset <= data_wr && is_flag_cmd;   // one cycle pulse
        end
    end

    // write payload, qualified by wr_en
    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr_addr <= addr_q;
            wr_data <= host_data;
        end
    end

    // the host issues one strobe per cycle
    assert property (@(posedge clk) disable iff (reset)
        !(addr_wr && data_wr))
        else $error("address and data strobes high together");

endmodule

`default_nettype wire

// File: opl3_pkg.sv
//////////////////////////////////////////////////////////////////////
// OPL3 register subsystem types
//   field width typedefs, register address and data
//   operator, channel and global parameter structs
//   timer state enum
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "opl3_cfg.svh"

package opl3_pkg;

    typedef logic [`OPL3_FNUM_W-1:0]  fnum_t;
    typedef logic [`OPL3_BLOCK_W-1:0] block_t;
    typedef logic [`OPL3_MULT_W-1:0]  mult_t;
    typedef logic [`OPL3_ENV_W-1:0]   env_t;
    typedef logic [`OPL3_TL_W-1:0]    tl_t;
    typedef logic [`OPL3_KSL_W-1:0]   ksl_t;
    typedef logic [`OPL3_WS_W-1:0]    ws_t;
    typedef logic [`OPL3_FB_W-1:0]    fb_t;
    typedef logic [`OPL3_TIMER_W-1:0] timer_t;

    typedef logic [`OPL3_ADDR_W-1:0]  reg_addr_t;   // {bank, offset}
    typedef logic [`OPL3_DATA_W-1:0]  reg_data_t;

    typedef struct packed {
        logic  am;      // tremolo enable
        logic  vib;     // vibrato enable
        logic  egt;     // sustained envelope
        logic  ksr;     // key scale rate
        mult_t mult;
        ksl_t  ksl;
        tl_t   tl;      // total level
        env_t  ar;
        env_t  dr;
        env_t  sl;
        env_t  rr;
        ws_t   ws;      // waveform select
    } op_params_t;

    typedef struct packed {
        fnum_t  fnum;
        block_t block;
        logic   kon;    // key on
        logic   cha;    // output routing
        logic   chb;
        logic   chc;
        logic   chd;
        fb_t    fb;     // feedback
        logic   cnt;    // synthesis type
    } ch_params_t;

    typedef struct packed {
        timer_t timer1;                         // presets
        timer_t timer2;
        logic   mt1;                            // flag masks
        logic   mt2;
        logic   st1;                            // start bits
        logic   st2;
        logic [`OPL3_CONN_SEL_W-1:0] connection_sel;  // 4-op pairing
        logic   is_new;                         // OPL3 mode
        logic   nts;
        logic   dam;
        logic   dvb;
        logic   ryt;                            // rhythm mode
        logic   bd;
        logic   sd;
        logic   tom;
        logic   tc;
        logic   hh;
    } glob_params_t;

    typedef enum logic {
        TIMER_IDLE,
        TIMER_RUN
    } timer_state_t;

endpackage

`default_nettype wire

// File: opl3_reg_array.sv
//////////////////////////////////////////////////////////////////////
// OPL3 register array
//   512 x 8 storage for both register banks
//   one byte written per cycle, all bytes cleared by reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "opl3_cfg.svh"

module opl3_reg_array (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 wr_en,
    input  wire opl3_pkg::reg_addr_t wr_addr,
    input  wire opl3_pkg::reg_data_t wr_data,
    output opl3_pkg::reg_data_t regs [`OPL3_NUM_REGS]
);
    import opl3_pkg::*;

    // every register reads as zero after reset, the decoder
    // relies on that for a silent, OPL2-mode start
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OPL3_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;   // wr_addr spans both banks
        end
    end

endmodule

`default_nettype wire

// File: opl3_reg_decode.sv
//////////////////////////////////////////////////////////////////////
// OPL3 register decoder
//   operator slot fields for 2 x 18 operators
//   channel fields for 2 x 9 channels
//   global timer, mode and rhythm fields
//   OPL2 waveform limit when is_new is clear
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "opl3_cfg.svh"

module opl3_reg_decode (
    input  wire opl3_pkg::reg_data_t regs [`OPL3_NUM_REGS],
    output opl3_pkg::op_params_t     op_params [2][18],
    output opl3_pkg::ch_params_t     ch_params [2][9],
    output opl3_pkg::glob_params_t   glob
);
    import opl3_pkg::*;

    localparam int BANK1 = `OPL3_BANK_OFFSET;

    always_comb begin
        glob.timer1 = regs['h02];
        glob.timer2 = regs['h03];

        glob.mt1 = regs['h04][6];
        glob.mt2 = regs['h04][5];
        glob.st2 = regs['h04][1];
        glob.st1 = regs['h04][0];

        glob.connection_sel = regs[BANK1 + 'h04][`OPL3_CONN_SEL_W-1:0];
        glob.is_new         = regs[BANK1 + 'h05][0];
        glob.nts            = regs['h08][6];   // keyboard split

        glob.dam = regs['hBD][7];   // tremolo depth
        glob.dvb = regs['hBD][6];   // vibrato depth
        glob.ryt = regs['hBD][5];
        glob.bd  = regs['hBD][4];
        glob.sd  = regs['hBD][3];
        glob.tom = regs['hBD][2];
        glob.tc  = regs['hBD][1];
        glob.hh  = regs['hBD][0];
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank

        // slot offsets come in three groups of six with a gap of two,
        // so operator n sits at offset n + 2 * (n / 6)
        for (genvar op = 0; op < 18; op++) begin : g_op
            localparam int BASE = b * BANK1 + op + 2 * (op / 6);

            always_comb begin
                op_params[b][op].am   = regs['h20 + BASE][7];
                op_params[b][op].vib  = regs['h20 + BASE][6];
                op_params[b][op].egt  = regs['h20 + BASE][5];
                op_params[b][op].ksr  = regs['h20 + BASE][4];
                op_params[b][op].mult = regs['h20 + BASE][3:0];

                op_params[b][op].ksl = regs['h40 + BASE][7:6];
                op_params[b][op].tl  = regs['h40 + BASE][5:0];

                op_params[b][op].ar = regs['h60 + BASE][7:4];
                op_params[b][op].dr = regs['h60 + BASE][3:0];

                op_params[b][op].sl = regs['h80 + BASE][7:4];
                op_params[b][op].rr = regs['h80 + BASE][3:0];

                // OPL2 has only four waveforms
                op_params[b][op].ws = regs['hE0 + BASE][2:0];
                if (!glob.is_new) begin
                    op_params[b][op].ws[2] = 1'b0;
                end
            end
        end

        for (genvar ch = 0; ch < 9; ch++) begin : g_ch
            localparam int BASE = b * BANK1 + ch;

            always_comb begin
                ch_params[b][ch].fnum  = {regs['hB0 + BASE][1:0], regs['hA0 + BASE]};
                ch_params[b][ch].kon   = regs['hB0 + BASE][5];
                ch_params[b][ch].block = regs['hB0 + BASE][4:2];

                ch_params[b][ch].chd = regs['hC0 + BASE][7];
                ch_params[b][ch].chc = regs['hC0 + BASE][6];
                ch_params[b][ch].chb = regs['hC0 + BASE][5];
                ch_params[b][ch].cha = regs['hC0 + BASE][4];
                ch_params[b][ch].fb  = regs['hC0 + BASE][3:1];
                ch_params[b][ch].cnt = regs['hC0 + BASE][0];
            end
        end
    end

endmodule

`default_nettype wire

// File: opl3_regs_top.sv
//////////////////////////////////////////////////////////////////////
// OPL3 register subsystem top
//   host port, register array, register decoder and timers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "opl3_cfg.svh"

module opl3_regs_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     addr_wr,
    input  wire                     data_wr,
    input  wire                     bank,
    input  wire opl3_pkg::reg_data_t host_data,
    output opl3_pkg::op_params_t    op_params [2][18],
    output opl3_pkg::ch_params_t    ch_params [2][9],
    output opl3_pkg::glob_params_t  glob,
    output logic [2:0]              status_flags,
    output logic                    irq
);
    import opl3_pkg::*;

    logic      wr_en;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    logic      flag_reset;
    reg_data_t regs [`OPL3_NUM_REGS];

    opl3_host_port host_port (
        .clk        (clk),
        .reset      (reset),
        .addr_wr    (addr_wr),
        .data_wr    (data_wr),
        .bank       (bank),
        .host_data  (host_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .flag_reset (flag_reset)
    );

    opl3_reg_array reg_array (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .regs    (regs)
    );

    opl3_reg_decode reg_decode (
        .regs      (regs),
        .op_params (op_params),
        .ch_params (ch_params),
        .glob      (glob)
    );

    opl3_timers timers (
        .clk          (clk),
        .reset        (reset),
        .glob         (glob),
        .flag_reset   (flag_reset),
        .status_flags (status_flags),
        .irq          (irq)
    );

endmodule

`default_nettype wire

// File: opl3_timers.sv
//////////////////////////////////////////////////////////////////////
// OPL3 timers
//   shared prescaler for the timer 1 and timer 2 ticks
//   two 8-bit up counters with preset reload
//   overflow flags with masks, flag reset and interrupt
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "opl3_cfg.svh"

module opl3_timers (
    input  wire                       clk,
    input  wire                       reset,
    input  wire opl3_pkg::glob_params_t glob,
    input  wire                       flag_reset,
    output logic [2:0]                status_flags,   // {irq, ft1, ft2}
    output logic                      irq
);
    import opl3_pkg::*;

    localparam int PRE_W = $clog2(`OPL3_TIMER1_TICK);
    localparam int DIV_W = $clog2(`OPL3_TIMER2_MULT);

    logic [PRE_W-1:0] pre_cnt;
    logic [DIV_W-1:0] div_cnt;      // timer 1 ticks within a timer 2 tick
    logic             tick1;

    logic [1:0]   start;            // index 0 is timer 1
    logic [1:0]   start_q;
    logic [1:0]   mask;
    logic [1:0]   tick;
    logic [1:0]   flag;
    timer_t       preset [2];
    timer_t       count  [2];
    timer_state_t state  [2];

    assign tick1 = (pre_cnt == PRE_W'(`OPL3_TIMER1_TICK - 1));

    assign tick[0] = tick1;
    assign tick[1] = tick1 && (div_cnt == DIV_W'(`OPL3_TIMER2_MULT - 1));

    assign start     = {glob.st2, glob.st1};
    assign mask      = {glob.mt2, glob.mt1};
    assign preset[0] = glob.timer1;
    assign preset[1] = glob.timer2;

    // free running, so the first tick lands anywhere in a period
    always_ff @(posedge clk) begin
        if (reset) begin
            pre_cnt <= '0;
            div_cnt <= '0;
        end else begin
            pre_cnt <= tick1 ? '0 : pre_cnt + 1'b1;
            if (tick1) begin
                div_cnt <= tick[1] ? '0 : div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q <= '0;
            flag    <= '0;
            for (int i = 0; i < 2; i++) begin
                state[i] <= TIMER_IDLE;
                count[i] <= '0;
            end
        end else begin
            start_q <= start;
            for (int i = 0; i < 2; i++) begin
                if (start[i] && !start_q[i]) begin
                    state[i] <= TIMER_RUN;
                    count[i] <= preset[i];
                end else if (!start[i]) begin
                    state[i] <= TIMER_IDLE;     // flag is kept
                end else if (state[i] == TIMER_RUN && tick[i]) begin
                    if (count[i] == '1) begin
                        count[i] <= preset[i];
                        if (!mask[i]) begin
                            flag[i] <= 1'b1;
                        end
                    end else begin
                        count[i] <= count[i] + 1'b1;
                    end
                end
            end
            if (flag_reset) begin
                flag <= '0;     // wins over a same-cycle overflow
            end
        end
    end

    assign irq          = |flag;
    assign status_flags = {irq, flag[0], flag[1]};

    assert property (@(posedge clk) disable iff (reset)
        status_flags[2] |-> |status_flags[1:0])
        else $error("irq without a timer flag");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the OPL3 register testbench with Verilator, run it, and scan the log.
# The run fails on a build error, a simulator error or a reported check failure.

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_opl3_regs \
    -Mdir obj_dir -o sim_opl3_regs > build.log 2>&1 &&
./obj_dir/sim_opl3_regs > sim.log 2>&1 &&
! grep -q "Checks failed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: tb_opl3_regs.sv
//////////////////////////////////////////////////////////////////////
// OPL3 register subsystem testbench
//   clock, reset and host write task
//   expected parameter models and compare tasks
//   operator, channel, global, timer and mask tests
//   cycle count timeout
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "opl3_cfg.svh"

module tb_opl3_regs;
    import opl3_pkg::*;

    localparam int BANK1     = `OPL3_BANK_OFFSET;
    localparam int T1_CYC    = `OPL3_TIMER1_TICK;
    localparam int T2_CYC    = `OPL3_TIMER1_TICK * `OPL3_TIMER2_MULT;
    localparam int T1_LIMIT  = 17 * T1_CYC + 4;     // one tick of slack plus pipeline
    localparam int T2_LIMIT  = 17 * T2_CYC + 4;
    localparam int N_WRITES  = 260;                 // host writes over all tests
    localparam int TIMEOUT   = 2 * (3 * N_WRITES + 2 * T1_LIMIT + 3 * T2_LIMIT);

    logic         clk = 1'b0;
    logic         reset;
    logic         addr_wr;
    logic         data_wr;
    logic         bank;
    reg_data_t    host_data;
    op_params_t   op_params [2][18];
    ch_params_t   ch_params [2][9];
    glob_params_t glob;
    logic [2:0]   status_flags;     // {irq, ft1, ft2}
    logic         irq;

    reg_data_t    shadow [`OPL3_NUM_REGS];  // expected register contents
    int           seed = 32'hb3f0_b490;
    int           cycle_count = 0;
    int           check_count = 0;
    int           error_count = 0;
    int           test_errors = 0;
    string        test_name;

    opl3_regs_top uut (
        .clk          (clk),
        .reset        (reset),
        .addr_wr      (addr_wr),
        .data_wr      (data_wr),
        .bank         (bank),
        .host_data    (host_data),
        .op_params    (op_params),
        .ch_params    (ch_params),
        .glob         (glob),
        .status_flags (status_flags),
        .irq          (irq)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic write_reg(input logic b, input reg_data_t addr, input reg_data_t data);
        @(negedge clk);
        addr_wr   = 1'b1;
        bank      = b;
        host_data = addr;
        @(negedge clk);
        addr_wr   = 1'b0;
        data_wr   = 1'b1;
        host_data = data;
        @(negedge clk);
        data_wr   = 1'b0;
        if (!(b == 1'b0 && addr == 8'h04 && data[7])) begin
            shadow[b * BANK1 + addr] = data;    // flag reset is not stored
        end
    endtask

    task automatic write_random(input logic b, input reg_data_t addr);
        int rnd;
        rnd = $random(seed);
        write_reg(b, addr, rnd[7:0]);
    endtask

    task automatic settle();
        @(negedge clk);     // array write edge
        @(negedge clk);
    endtask

    function automatic op_params_t expect_op(input int b, input int idx);
        op_params_t e;
        int         base;
        // three groups of six slots, each group two offsets further on
        base = b * BANK1 + ((idx < 6) ? idx : (idx < 12) ? idx + 2 : idx + 4);
        {e.am, e.vib, e.egt, e.ksr, e.mult} = shadow[base + 'h20];
        {e.ksl, e.tl} = shadow[base + 'h40];
        {e.ar, e.dr}  = shadow[base + 'h60];
        {e.sl, e.rr}  = shadow[base + 'h80];
        e.ws = shadow[base + 'hE0][2:0];
        if (!shadow[BANK1 + 'h05][0]) begin
            e.ws[2] = 1'b0;     // OPL2 waveform limit
        end
        return e;
    endfunction

    function automatic ch_params_t expect_ch(input int b, input int ch);
        ch_params_t e;
        int         base;
        base = b * BANK1 + ch;
        e.fnum  = {shadow[base + 'hB0][1:0], shadow[base + 'hA0]};
        e.kon   = shadow[base + 'hB0][5];
        e.block = shadow[base + 'hB0][4:2];
        {e.chd, e.chc, e.chb, e.cha, e.fb, e.cnt} = shadow[base + 'hC0];
        return e;
    endfunction

    function automatic glob_params_t expect_glob();
        glob_params_t e;
        e.timer1 = shadow['h02];
        e.timer2 = shadow['h03];
        e.mt1    = shadow['h04][6];
        e.mt2    = shadow['h04][5];
        e.st2    = shadow['h04][1];
        e.st1    = shadow['h04][0];
        e.connection_sel = shadow[BANK1 + 'h04][`OPL3_CONN_SEL_W-1:0];
        e.is_new = shadow[BANK1 + 'h05][0];
        e.nts    = shadow['h08][6];
        {e.dam, e.dvb, e.ryt, e.bd, e.sd, e.tom, e.tc, e.hh} = shadow['hBD];
        return e;
    endfunction

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_op(input string what, input op_params_t exp, input op_params_t act);
        check_count++;
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_ch(input string what, input ch_params_t exp, input ch_params_t act);
        check_count++;
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_glob(input glob_params_t exp, input glob_params_t act);
        check_count++;
        if (act !== exp) begin
            $display("ERROR %s glob: expected %h, actual %h", test_name, exp, act);
            note_error();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
            note_error();
        end
    endtask

    // idx 1 is ft1, idx 0 is ft2
    task automatic wait_flag(input int idx, input int lo, input int hi);
        int cycles;
        cycles = 0;
        check_count++;
        while (!status_flags[idx] && cycles <= hi) begin
            @(negedge clk);
            cycles++;
        end
        if (!status_flags[idx]) begin
            $display("%s: timer flag did not rise within %0d cycles", test_name, hi);
            note_error();
        end else if (cycles < lo) begin
            $display("%s: timer flag rose early, after %0d cycles", test_name, cycles);
            note_error();
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%-16s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAIL", test_errors);
    endtask

    task automatic test_operator_map();
        start_test("operator_map");
        write_reg(1'b1, 8'h05, 8'h01);      // OPL3 mode
        for (int b = 0; b < 2; b++) begin
            for (int s = 0; s < 22; s++) begin
                if (s % 8 < 6) begin
                    write_random(b[0], 8'h20 + s[7:0]);
                    write_random(b[0], 8'h40 + s[7:0]);
                    write_random(b[0], 8'h60 + s[7:0]);
                    write_random(b[0], 8'h80 + s[7:0]);
                    write_random(b[0], 8'hE0 + s[7:0]);
                end
            end
        end
        settle();
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 18; i++) begin
                check_op($sformatf("op[%0d][%0d]", b, i), expect_op(b, i), op_params[b][i]);
            end
        end
        end_test();
    endtask

    task automatic test_channels();
        start_test("channels");
        for (int b = 0; b < 2; b++) begin
            for (int c = 0; c < 9; c++) begin
                write_random(b[0], 8'hA0 + c[7:0]);
                write_random(b[0], 8'hB0 + c[7:0]);
                write_random(b[0], 8'hC0 + c[7:0]);
            end
        end
        settle();
        for (int b = 0; b < 2; b++) begin
            for (int c = 0; c < 9; c++) begin
                check_ch($sformatf("ch[%0d][%0d]", b, c), expect_ch(b, c), ch_params[b][c]);
            end
        end
        end_test();
    endtask

    task automatic test_globals();
        start_test("globals");
        write_random(1'b0, 8'hBD);
        write_random(1'b0, 8'h08);
        write_random(1'b1, 8'h04);
        write_reg(1'b1, 8'h05, 8'h00);      // back to OPL2 mode
        write_reg(1'b0, 8'hE3, 8'h07);      // slot 3, operator 3
        settle();
        check_glob(expect_glob(), glob);
        check_op("op[0][3] opl2", expect_op(0, 3), op_params[0][3]);
        check_bit("ws[2] opl2", 1'b0, op_params[0][3].ws[2]);
        write_reg(1'b1, 8'h05, 8'h01);
        settle();
        check_op("op[0][3] opl3", expect_op(0, 3), op_params[0][3]);
        check_bit("ws[2] opl3", 1'b1, op_params[0][3].ws[2]);
        end_test();
    endtask

    task automatic test_timer_overflow();
        start_test("timer_overflow");
        write_reg(1'b0, 8'h02, 8'hF0);
        write_reg(1'b0, 8'h04, 8'h01);      // start timer 1
        wait_flag(1, 15 * T1_CYC, T1_LIMIT);
        check_bit("irq t1", 1'b1, irq);
        check_bit("status irq t1", 1'b1, status_flags[2]);
        write_reg(1'b0, 8'h03, 8'hF0);
        write_reg(1'b0, 8'h04, 8'h02);      // stop timer 1, start timer 2
        wait_flag(0, 15 * T2_CYC, T2_LIMIT);
        check_bit("ft1 kept", 1'b1, status_flags[1]);
        check_bit("irq t2", 1'b1, irq);
        check_glob(expect_glob(), glob);
        end_test();
    endtask

    task automatic test_mask_and_reset();
        logic seen;
        start_test("mask_and_reset");
        write_reg(1'b0, 8'h04, 8'h00);
        write_reg(1'b0, 8'h04, 8'h80);
        settle();
        check_bit("ft1 cleared", 1'b0, status_flags[1]);
        check_bit("ft2 cleared", 1'b0, status_flags[0]);
        check_bit("irq cleared", 1'b0, irq);
        write_reg(1'b0, 8'h04, 8'h22);      // masked timer 2
        seen = 1'b0;
        repeat (T2_LIMIT + T2_CYC) begin
            @(negedge clk);
            seen = seen | status_flags[0];
        end
        check_bit("ft2 masked", 1'b0, seen);
        write_reg(1'b0, 8'h04, 8'h21);      // timer 1 on, timer 2 mask kept
        wait_flag(1, 15 * T1_CYC, T1_LIMIT);
        write_reg(1'b0, 8'h04, 8'h80);
        settle();
        check_bit("ft1 reset", 1'b0, status_flags[1]);
        check_bit("irq reset", 1'b0, irq);
        check_bit("st1 kept", 1'b1, glob.st1);
        check_glob(expect_glob(), glob);
        end_test();
    endtask

    initial begin
        reset     = 1'b1;
        addr_wr   = 1'b0;
        data_wr   = 1'b0;
        bank      = 1'b0;
        host_data = '0;
        for (int i = 0; i < `OPL3_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_operator_map();
        test_channels();
        test_globals();
        test_timer_overflow();
        test_mask_and_reset();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
